// File: common/lsu_pkg.sv
package lsu_pkg;

    ////////////////////
    // data path widths
    ////////////////////

    // one machine word
    localparam int XLEN = 32;

    ////////////////////
    // access size code
    ////////////////////

    // matches the low two funct3 bits of the load/store opcodes
    typedef enum logic [1:0] {
        // lb, lbu, sb
        SIZE_BYTE = 2'd0,
        // lh, lhu, sh
        SIZE_HALF = 2'd1,
        // lw, sw
        SIZE_WORD = 2'd2,
        // never issued by the core
        SIZE_RSVD = 2'd3
    } access_size_t;

    ////////////////////
    // memory word views
    ////////////////////

    // same 32 bits seen two ways
    // bytes[0] is the lowest lane, little endian
    // halves[0] covers lanes 0-1, halves[1] lanes 2-3
    typedef union packed {
        // per-lane view, one entry per byte enable
        logic [XLEN/8-1:0][7:0] bytes;
        // halfword view for lh/lhu/sh
        logic [XLEN/16-1:0][15:0] halves;
    } mem_word_t;

endpackage

// File: common/mem_access_if.sv
`timescale 1ns/1ps

// decoded access, all levels, valid in the request cycle
interface mem_access_if #(
    parameter int ADDR_WIDTH = 10
);
    import lsu_pkg::*;

    // word address inside the memory
    logic [ADDR_WIDTH-1:0] word_index;
    // low two address bits
    logic [1:0] byte_lane;
    // access size as requested
    access_size_t size;
    // per-byte write enables, already qualified by we
    logic [XLEN/8-1:0] byte_en;
    // store data moved into its lanes
    mem_word_t wdata_lanes;
    // halfword or word not on its natural boundary
    logic misaligned;

    // decoder produces everything
    modport decoder (
        output word_index,
        output byte_lane,
        output size,
        output byte_en,
        output wdata_lanes,
        output misaligned
    );

    // ram only needs the write side and the index
    modport ram (
        input word_index,
        input byte_en,
        input wdata_lanes
    );

    // load extender picks and extends the read word
    modport extender (
        input byte_lane,
        input size,
        input misaligned
    );

endinterface

// File: lsu/lsu_access_decode.sv
`timescale 1ns/1ps

module lsu_access_decode #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic [lsu_pkg::XLEN-1:0] addr,
    input  lsu_pkg::access_size_t    size,
    input  logic [lsu_pkg::XLEN-1:0] wdata,
    input  logic                     we,
    mem_access_if.decoder            acc
);
    import lsu_pkg::*;

    logic              mis;
    logic [XLEN/8-1:0] lane_mask;
    logic [XLEN/8-1:0] lane_en;
    mem_word_t         placed;

    ////////////////////
    // address split
    ////////////////////

    // bits above the index dropped so the address wraps
    assign acc.word_index = addr[ADDR_WIDTH+1:2];
    assign acc.byte_lane  = addr[1:0];
    assign acc.size       = size;

    ////////////////////
    // lane enables
    ////////////////////

    always_comb
    begin
        // bytes are always aligned
        case (size)
            SIZE_HALF: mis = addr[0];
            SIZE_WORD: mis = |addr[1:0];
            default:   mis = 1'b0;
        endcase

        // lanes touched by the access
        case (size)
            SIZE_BYTE: lane_mask = 4'b0001 << addr[1:0];
            SIZE_HALF: lane_mask = addr[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: lane_mask = 4'b1111;
            default:   lane_mask = 4'b0000;
        endcase

        // misaligned store must not touch memory
        lane_en = (we && !mis) ? lane_mask : '0;
    end

    assign acc.misaligned = mis;
    assign acc.byte_en    = lane_en;

    ////////////////////
    // store data lanes
    ////////////////////

    // low byte or low half copied into every lane
    // byte_en then picks the lanes that land
    always_comb
    begin
        for (int i = 0; i < XLEN/8; i++)
        begin
            case (size)
                SIZE_BYTE: placed.bytes[i] = wdata[7:0];
                // odd lanes take the upper byte of the halfword
                SIZE_HALF: placed.bytes[i] = (i % 2 == 1) ? wdata[15:8] : wdata[7:0];
                default:   placed.bytes[i] = wdata[8*i +: 8];
            endcase
        end
    end

    assign acc.wdata_lanes = placed;

    // checks on what the ram will see
    always_comb
    begin
        // core never issues the reserved size
        if (!$isunknown(size))
        begin
            assert (size != SIZE_RSVD)
                else $error("reserved access size code on memory request");
        end
        // odd halfword or unaligned word must never reach the ram write port
        if (!$isunknown({addr[1:0], size, acc.byte_en}))
        begin
            assert (acc.byte_en == '0
                    || !((size == SIZE_HALF && addr[0])
                         || (size == SIZE_WORD && |addr[1:0])))
                else $error("byte enable raised on a misaligned access");
        end
    end

endmodule

// File: lsu/lsu_load_extend.sv
`timescale 1ns/1ps

module lsu_load_extend (
    mem_access_if.extender           acc,
    input  logic [lsu_pkg::XLEN-1:0] rdata,
    input  logic                     sign,
    input  logic                     re,
    output logic [lsu_pkg::XLEN-1:0] load_data
);
    import lsu_pkg::*;

    mem_word_t       rword;
    logic [7:0]      pick_byte;
    logic [15:0]     pick_half;
    logic [XLEN-1:0] extended;

    // read word viewed as lanes or halves
    assign rword = rdata;

    ////////////////////
    // lane select
    ////////////////////

    // byte at its lane, halfword by the upper lane bit
    assign pick_byte = rword.bytes[acc.byte_lane];
    assign pick_half = rword.halves[acc.byte_lane[1]];

    ////////////////////
    // sign / zero ext
    ////////////////////

    always_comb
    begin
        case (acc.size)
            // lb / lbu
            SIZE_BYTE: extended = {{(XLEN-8){sign & pick_byte[7]}}, pick_byte};
            // lh / lhu, truly sign extended
            SIZE_HALF: extended = {{(XLEN-16){sign & pick_half[15]}}, pick_half};
            // lw passes straight through
            SIZE_WORD: extended = rword;
            default:   extended = '0;
        endcase
    end

    // nothing leaks out without a read, misaligned reads give zero
    assign load_data = (re && !acc.misaligned) ? extended : '0;

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                     clk,
    input  logic                     rst_n,
    mem_access_if.ram                acc,
    output logic [lsu_pkg::XLEN-1:0] rdata
);
    import lsu_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    ////////////////////
    // storage
    ////////////////////

    // one entry per word, byte view used for writes
    mem_word_t mem [DEPTH];

    ////////////////////
    // write port
    ////////////////////

    // one enable per lane, maps onto block ram byte writes
    // held off while rst_n is low
    always_ff @(posedge clk)
    begin
        if (rst_n)
        begin
            for (int i = 0; i < XLEN/8; i++)
            begin
                if (acc.byte_en[i])
                begin
                    mem[acc.word_index].bytes[i] <= acc.wdata_lanes.bytes[i];
                end
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // asynchronous read, whole word, lane pick is downstream
    assign rdata = mem[acc.word_index];

endmodule

// File: rtl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [lsu_pkg::XLEN-1:0] addr,
    input  lsu_pkg::access_size_t    size,
    input  logic                     sign,
    input  logic                     we,
    input  logic                     re,
    input  logic [lsu_pkg::XLEN-1:0] wdata,
    output logic [lsu_pkg::XLEN-1:0] load_data,
    output logic                     misaligned
);
    import lsu_pkg::*;

    // raw word out of the ram
    logic [XLEN-1:0] ram_rdata;

    ////////////////////
    // decoded access
    ////////////////////

    mem_access_if #(.ADDR_WIDTH(ADDR_WIDTH)) acc_bus ();

    // address split, alignment, byte enables, store lanes
    lsu_access_decode #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_decode (
        .addr  (addr),
        .size  (size),
        .wdata (wdata),
        .we    (we),
        .acc   (acc_bus.decoder)
    );

    ////////////////////
    // memory, extend
    ////////////////////

    // writes on the edge, reads combinational
    data_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .acc   (acc_bus.ram),
        .rdata (ram_rdata)
    );

    // lane pick and sign/zero extension of the load
    lsu_load_extend u_extend (
        .acc       (acc_bus.extender),
        .rdata     (ram_rdata),
        .sign      (sign),
        .re        (re),
        .load_data (load_data)
    );

    // flag comes from the one place it is decided
    assign misaligned = acc_bus.misaligned;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_mem_stage -f verilog.f \
    -o sim_mem_stage > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/sim_mem_stage > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

// File: verif/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import lsu_pkg::*;

    localparam int ADDR_WIDTH = 10;
    localparam int DEPTH      = 2 ** ADDR_WIDTH;
    localparam int PERIOD     = 40;

    // word addresses used by the table
    localparam logic [31:0] A_ADDR = 32'h0000_0040;
    localparam logic [31:0] B_ADDR = 32'h0000_0080;
    localparam logic [31:0] C_ADDR = 32'h0000_0100;
    localparam logic [31:0] D_ADDR = 32'h0000_0200;
    // value of the store tried while in reset
    localparam logic [31:0] RESET_WORD = 32'h5ee0_d00d;

    // one table row
    typedef struct packed {
        logic [31:0]  addr;
        access_size_t size;
        logic         sign;
        logic         we;
        logic         re;
        logic [31:0]  wdata;
    } stim_t;

    logic             clk;
    logic             rst_n;
    logic [31:0]      addr;
    access_size_t     size;
    logic             sign;
    logic             we;
    logic             re;
    logic [31:0]      wdata;
    logic [31:0]      load_data;
    logic             misaligned;

    stim_t            stim_q[$];
    // reference memory, little endian bytes
    logic [7:0]       ref_mem [4*DEPTH];

    mem_stage #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .size       (size),
        .sign       (sign),
        .we         (we),
        .re         (re),
        .wdata      (wdata),
        .load_data  (load_data),
        .misaligned (misaligned)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    ////////////////////
    // reference model
    ////////////////////

    // upper address bits dropped, address wraps in the memory
    function automatic int byte_base(input logic [31:0] a);
        return int'(a[ADDR_WIDTH+1:2]) * 4;
    endfunction

    // halfword needs bit 0 clear, word needs both low bits clear
    function automatic logic misaligned_rule(input logic [31:0] a, input access_size_t sz);
        case (sz)
            SIZE_HALF: return a[0];
            SIZE_WORD: return a[1:0] != 2'b00;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] expected_load(input stim_t e);
        int          base;
        int          lane;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        base = byte_base(e.addr);
        lane = int'(e.addr[1:0]);
        w = '0;
        // no read strobe or bad alignment, nothing comes out
        if (!e.re || misaligned_rule(e.addr, e.size))
            return '0;
        case (e.size)
            SIZE_BYTE:
            begin
                b = ref_mem[base + lane];
                w = e.sign ? {{24{b[7]}}, b} : {24'h0, b};
            end
            SIZE_HALF:
            begin
                h = {ref_mem[base + lane + 1], ref_mem[base + lane]};
                w = e.sign ? {{16{h[15]}}, h} : {16'h0, h};
            end
            SIZE_WORD:
                w = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
            default:
                w = '0;
        endcase
        return w;
    endfunction

    // store lands at the edge, only when aligned
    task automatic update_model(input stim_t e);
        int base;
        int lane;
        base = byte_base(e.addr);
        lane = int'(e.addr[1:0]);
        if (!e.we || misaligned_rule(e.addr, e.size))
            return;
        case (e.size)
            SIZE_BYTE:
                ref_mem[base + lane] = e.wdata[7:0];
            SIZE_HALF:
            begin
                ref_mem[base + lane]     = e.wdata[7:0];
                ref_mem[base + lane + 1] = e.wdata[15:8];
            end
            SIZE_WORD:
                for (int i = 0; i < 4; i++)
                    ref_mem[base + i] = e.wdata[8*i +: 8];
            default:
                ;
        endcase
    endtask

    ////////////////////
    // error reporting
    ////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        $display("Test failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping on error");
    endtask

    ////////////////////
    // stimulus table
    ////////////////////

    // rnd replaces wdata with a random word
    task automatic add_entry(input logic [31:0] a, input access_size_t sz, input logic sg,
                             input logic w, input logic r, input logic [31:0] d,
                             input logic rnd);
        stim_t e;
        e.addr  = a;
        e.size  = sz;
        e.sign  = sg;
        e.we    = w;
        e.re    = r;
        e.wdata = rnd ? $urandom : d;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        // word store then load, reset write must be gone
        add_entry(A_ADDR, SIZE_WORD, 1'b0, 1'b1, 1'b0, 32'h0, 1'b1);
        add_entry(A_ADDR, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        // byte merge over a known word
        add_entry(B_ADDR, SIZE_WORD, 1'b0, 1'b1, 1'b0, 32'ha5a5_5a5a, 1'b0);
        add_entry(B_ADDR, SIZE_BYTE, 1'b0, 1'b1, 1'b0, 32'h0000_0081, 1'b0);
        add_entry(B_ADDR + 1, SIZE_BYTE, 1'b0, 1'b1, 1'b0, 32'hffff_ff7f, 1'b0);
        add_entry(B_ADDR, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(B_ADDR + 2, SIZE_BYTE, 1'b0, 1'b1, 1'b0, 32'h0, 1'b1);
        add_entry(B_ADDR + 3, SIZE_BYTE, 1'b0, 1'b1, 1'b0, 32'h1234_56c3, 1'b0);
        add_entry(B_ADDR, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        // byte loads, bit 7 set in lanes 0 and 3, clear in lane 1
        add_entry(B_ADDR, SIZE_BYTE, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(B_ADDR, SIZE_BYTE, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(B_ADDR + 1, SIZE_BYTE, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(B_ADDR + 1, SIZE_BYTE, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(B_ADDR + 2, SIZE_BYTE, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(B_ADDR + 3, SIZE_BYTE, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0);
        // halfwords at lane 0 and lane 2
        add_entry(C_ADDR, SIZE_HALF, 1'b0, 1'b1, 1'b0, 32'h1234_8001, 1'b0);
        add_entry(C_ADDR + 2, SIZE_HALF, 1'b0, 1'b1, 1'b0, 32'hdead_7ffe, 1'b0);
        add_entry(C_ADDR, SIZE_HALF, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(C_ADDR, SIZE_HALF, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(C_ADDR + 2, SIZE_HALF, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(C_ADDR + 2, SIZE_HALF, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(C_ADDR, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(C_ADDR + 2, SIZE_HALF, 1'b0, 1'b1, 1'b0, 32'h0, 1'b1);
        add_entry(C_ADDR + 2, SIZE_HALF, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0);
        // misaligned loads read zero
        add_entry(C_ADDR + 1, SIZE_HALF, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(C_ADDR + 3, SIZE_HALF, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(C_ADDR + 1, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(C_ADDR + 2, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(C_ADDR + 3, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        // misaligned stores, word must stay as it was
        add_entry(C_ADDR + 2, SIZE_WORD, 1'b0, 1'b1, 1'b0, 32'h0, 1'b1);
        add_entry(C_ADDR + 1, SIZE_HALF, 1'b0, 1'b1, 1'b0, 32'h0, 1'b1);
        add_entry(C_ADDR, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        // read strobe low gives zero anywhere
        add_entry(A_ADDR, SIZE_WORD, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
        add_entry(B_ADDR + 1, SIZE_BYTE, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
        add_entry(32'h0000_0ffc, SIZE_WORD, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
        // high address bits wrap onto the same word
        add_entry(A_ADDR | 32'h0000_1000, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry(D_ADDR | 32'h8000_2000, SIZE_WORD, 1'b0, 1'b1, 1'b0, 32'h0, 1'b1);
        add_entry(D_ADDR, SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_entry((D_ADDR + 2) | 32'h4000_0000, SIZE_HALF, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0);
    endtask

    task automatic drive_entry(input stim_t e);
        addr  = e.addr;
        size  = e.size;
        sign  = e.sign;
        we    = e.we;
        re    = e.re;
        wdata = e.wdata;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        stim_t       e;
        logic [31:0] exp_data;
        logic        exp_mis;
        rst_n = 1'b0;
        addr  = '0;
        size  = SIZE_BYTE;
        sign  = 1'b0;
        we    = 1'b0;
        re    = 1'b0;
        wdata = '0;
        void'($urandom(32'hf483d1cd));
        build_table();

        // store attempted while in reset
        @(posedge clk);
        #2;
        we    = 1'b1;
        size  = SIZE_WORD;
        addr  = A_ADDR;
        wdata = RESET_WORD;
        @(posedge clk);
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        we    = 1'b0;
        re    = 1'b1;
        #(PERIOD - 4);
        assert (load_data !== RESET_WORD)
            else report_problem("a word written while rst_n was low reached the memory");

        foreach (stim_q[i])
        begin
            e = stim_q[i];
            @(posedge clk);
            #2;
            drive_entry(e);
            // sample just ahead of the next edge
            #(PERIOD - 4);
            exp_data = expected_load(e);
            exp_mis  = misaligned_rule(e.addr, e.size);
            assert (load_data === exp_data)
                else report_mismatch("load_data", exp_data, load_data);
            assert (misaligned === exp_mis)
                else report_mismatch("misaligned", {31'h0, exp_mis}, {31'h0, misaligned});
            update_model(e);
        end

        $display("Test passed");
        $finish;
    end

    // watchdog, sized from the table once it is built
    initial
    begin
        int limit;
        #1;
        limit = 2 * stim_q.size() * PERIOD + 3 * PERIOD;
        #(limit);
        $display("simulation ran past its time limit without finishing the table");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verilog.f
common/lsu_pkg.sv
common/mem_access_if.sv
lsu/lsu_access_decode.sv
lsu/lsu_load_extend.sv
rtl/data_ram.sv
rtl/mem_stage.sv
verif/tb_mem_stage.sv
